// ==== hdl/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

    // memory geometry
    localparam int mem_aw    = 14;  // half-word address, 16k x 16
    localparam int word_aw   = 13;  // 32-bit word address
    localparam int region_aw = 11;  // 2k words per slot region
    localparam int num_slots = 3;
    localparam int slot_iw   = $clog2(num_slots);  // slot index bits

    // word base of each slot region, regions never overlap
    localparam logic [word_aw-1:0] slot_base [num_slots] = '{
        13'd0,
        13'd2048,
        13'd4096
    };

    localparam int rd_latency = 2;  // array rd to rdata

    // controller states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_lo   = 2'd1;  // low half-word on the bus
    localparam logic [1:0] st_hi   = 2'd2;  // high half-word on the bus
    localparam logic [1:0] st_wait = 2'd3;  // read data still in flight

    // one 32-bit word seen whole, as half-words or as bytes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;   // [0] is the low half-word
        logic [3:0][7:0]  bytes;  // [0] is the lowest byte
    } cache_word_u;

endpackage

`default_nettype wire

// ==== hdl/sdram_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_array
    import sdram_pkg::*;
(
    input  logic              clk,
    input  logic [mem_aw-1:0] addr,
    input  logic              rd,
    input  logic              wr,
    input  logic [1:0]        be,     // [1] upper byte
    input  logic [15:0]       wdata,
    output logic [15:0]       rdata   // valid two cycles after rd
);

    logic [15:0] mem [2**mem_aw];
    logic [15:0] rd_q;                // first read stage

    initial begin
        for (int i = 0; i < 2**mem_aw; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr && be[0]) begin
            mem[addr][7:0] <= wdata[7:0];
        end
        if (wr && be[1]) begin
            mem[addr][15:8] <= wdata[15:8];
        end
    end

    // two registered stages on the read side
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_q <= mem[addr];
        end
        rdata <= rd_q;
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req,
    input  logic               mem_rnw,
    input  logic [word_aw-1:0] mem_addr,
    input  logic [31:0]        mem_wdata,
    input  logic [3:0]         mem_wmask,
    input  logic [15:0]        ram_rdata,
    output logic               mem_ack,    // one cycle, access complete
    output logic               mem_busy,
    output logic [31:0]        mem_rdata,
    output logic [mem_aw-1:0]  ram_addr,
    output logic               ram_rd,
    output logic               ram_wr,
    output logic [1:0]         ram_be,
    output logic [15:0]        ram_wdata
);

    logic [1:0]            state;
    logic                  issue;     // half-word access on the bus
    logic                  upper;     // high half selected
    logic [rd_latency-1:0] rd_pipe;   // reads in flight
    logic [rd_latency-1:0] hi_pipe;   // half each in-flight read belongs to
    logic                  rd_done;   // a half-word is back from the array
    cache_word_u           wsplit;
    cache_word_u           asm_q;     // returned halves collect here

    assign issue    = state == st_lo || state == st_hi;
    assign upper    = state == st_hi;
    assign mem_busy = state != st_idle;
    assign rd_done  = rd_pipe[rd_latency-1];

    // fields are held by the slot for the whole access
    assign wsplit    = mem_wdata;
    assign ram_addr  = {mem_addr, upper};  // low half at even address
    assign ram_rd    = issue && mem_rnw;
    assign ram_wr    = issue && !mem_rnw;
    assign ram_be    = upper ? mem_wmask[3:2] : mem_wmask[1:0];
    assign ram_wdata = wsplit.half[upper];
    assign mem_rdata = asm_q.word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            mem_ack <= 1'b0;
            rd_pipe <= '0;
            hi_pipe <= '0;
        end else begin
            mem_ack <= 1'b0;
            rd_pipe <= {rd_pipe[rd_latency-2:0], ram_rd};
            hi_pipe <= {hi_pipe[rd_latency-2:0], upper};
            case (state)
                st_idle: begin
                    // while mem_ack is high the finished request is still shown
                    if (mem_req && !mem_ack) begin
                        state <= st_lo;
                    end
                end
                st_lo: begin
                    state <= st_hi;
                end
                st_hi: begin
                    if (mem_rnw) begin
                        state <= st_wait;
                    end else begin
                        state   <= st_idle;  // both halves written
                        mem_ack <= 1'b1;
                    end
                end
                default: begin
                    // high half arriving ends the read
                    if (rd_done && hi_pipe[rd_latency-1]) begin
                        state   <= st_idle;
                        mem_ack <= 1'b1;
                    end
                end
            endcase
        end
    end

    // read assembly, no reset
    always_ff @(posedge clk) begin
        if (rd_done) begin
            asm_q.half[hi_pipe[rd_latency-1]] <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter
    import sdram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_slots-1:0] req,
    input  logic [num_slots-1:0] rnw,
    input  logic [word_aw-1:0]   addr0,
    input  logic [word_aw-1:0]   addr1,
    input  logic [word_aw-1:0]   addr2,
    input  logic [31:0]          wdata0,
    input  logic [31:0]          wdata1,
    input  logic [31:0]          wdata2,
    input  logic [3:0]           wmask0,
    input  logic [3:0]           wmask1,
    input  logic [3:0]           wmask2,
    input  logic                 mem_ack,
    input  logic                 mem_busy,
    output logic [num_slots-1:0] ack,
    output logic                 mem_req,
    output logic                 mem_rnw,
    output logic [word_aw-1:0]   mem_addr,
    output logic [31:0]          mem_wdata,
    output logic [3:0]           mem_wmask
);

    logic [num_slots-1:0] grant;    // one-hot, held until ack
    logic [num_slots-1:0] nxt;      // candidate grant
    logic [slot_iw-1:0]   last;     // last slot granted
    logic [slot_iw-1:0]   nxt_idx;

    // search starts at the slot after the last one served
    always_comb begin : pick
        int idx;
        nxt     = '0;
        nxt_idx = last;
        for (int k = 1; k <= num_slots; k++) begin
            idx = int'(last) + k;
            if (idx >= num_slots) begin
                idx = idx - num_slots;  // wrap
            end
            if (nxt == '0 && req[idx]) begin
                nxt[idx] = 1'b1;
                nxt_idx  = slot_iw'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
            last  <= slot_iw'(num_slots - 1);  // slot 0 wins first
        end else if (grant != '0) begin
            if (mem_ack) begin
                grant <= '0;
            end
        end else if (!mem_busy) begin
            grant <= nxt;
            if (nxt != '0) begin
                last <= nxt_idx;
            end
        end
    end

    // and-or mux on the one-hot grant
    assign mem_req   = |(grant & req);
    assign mem_rnw   = |(grant & rnw);
    assign mem_addr  = ({word_aw{grant[0]}} & addr0) |
                       ({word_aw{grant[1]}} & addr1) |
                       ({word_aw{grant[2]}} & addr2);
    assign mem_wdata = ({32{grant[0]}} & wdata0) |
                       ({32{grant[1]}} & wdata1) |
                       ({32{grant[2]}} & wdata2);
    assign mem_wmask = ({4{grant[0]}} & wmask0) |
                       ({4{grant[1]}} & wmask1) |
                       ({4{grant[2]}} & wmask2);
    assign ack       = grant & {num_slots{mem_ack}};  // only the granted slot

endmodule

`default_nettype wire

// ==== hdl/sdram_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_slot
    import sdram_pkg::*;
#(
    parameter int dw      = 8,   // 8, 16 or 32 bit client
    parameter int slot_id = 0    // picks the region base
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [region_aw+1-$clog2(dw/8):0]  addr,     // client address in dw units
    input  logic                               addr_ok,  // addr, wr and wdata are valid
    input  logic                               wr,
    input  logic [dw-1:0]                      wdata,
    input  logic                               ack,      // memory access finished
    input  logic [31:0]                        rdata,
    output logic                               data_ok,  // one-cycle strobe to client
    output logic [dw-1:0]                      dout,
    output logic                               req,
    output logic                               rnw,
    output logic [word_aw-1:0]                 waddr,
    output logic [31:0]                        wdata32,
    output logic [3:0]                         wmask
);

    logic [region_aw+1:0] byte_addr;      // client address in bytes
    logic [region_aw-1:0] w_idx;          // word within the region
    logic [1:0]           off;            // byte lane in the word
    logic [31:0]          line_data [2];
    logic [region_aw-1:0] line_tag  [2];
    logic [1:0]           line_vld;
    logic [1:0]           hit;
    logic                 repl;           // line to refill next
    logic                 from_mem;       // dout taken from the fetched word
    logic [31:0]          mem_word;
    cache_word_u          src;

    // scale to bytes then split word index and lane
    assign byte_addr = (region_aw+2)'(addr) << $clog2(dw/8);
    assign w_idx     = byte_addr[region_aw+1:2];
    assign off       = byte_addr[1:0];

    assign hit[0] = line_vld[0] && line_tag[0] == w_idx;
    assign hit[1] = line_vld[1] && line_tag[1] == w_idx;

    // request fields come straight from the held client inputs
    assign rnw     = ~wr;
    assign waddr   = slot_base[slot_id] + word_aw'(w_idx);  // region offset
    assign wdata32 = {(32/dw){wdata}};                      // copy to every lane

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req      <= 1'b0;
            data_ok  <= 1'b0;
            from_mem <= 1'b0;
            line_vld <= 2'b00;
            repl     <= 1'b0;
        end else begin
            data_ok  <= ack;          // miss or write done
            from_mem <= ack && !wr;
            if (ack) begin
                req <= 1'b0;
                if (!wr) begin
                    // fetched word goes into the line the pointer names
                    line_vld[repl] <= 1'b1;
                    repl           <= ~repl;
                end else begin
                    for (int i = 0; i < 2; i++) begin
                        if (hit[i]) begin
                            line_vld[i] <= 1'b0;   // stale copy
                            repl        <= 1'(i);  // refill the freed line first
                        end
                    end
                end
            end else if (addr_ok && !req && !data_ok) begin
                // data_ok high means the client still shows the old request
                if (!wr && |hit) begin
                    data_ok <= 1'b1;  // answered from cache
                end else begin
                    req <= 1'b1;      // miss or write through
                end
            end
        end
    end

    // line payload and tags
    always_ff @(posedge clk) begin
        if (ack && !wr) begin
            line_data[repl] <= rdata;
            line_tag[repl]  <= w_idx;
            mem_word        <= rdata;
        end
    end

    always_comb begin
        if (from_mem) begin
            src = mem_word;
        end else if (hit[0]) begin
            src = line_data[0];
        end else begin
            src = line_data[1];
        end
    end

    // lane select and write mask per client width
    generate
        if (dw == 8) begin : g_byte
            assign dout  = src.bytes[off];
            assign wmask = 4'b0001 << off;
        end else if (dw == 16) begin : g_half
            assign dout  = src.half[off[1]];
            assign wmask = off[1] ? 4'b1100 : 4'b0011;
        end else begin : g_word
            assign dout  = src.word;
            assign wmask = 4'b1111;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/sdram_sys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_sys_top
    import sdram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // slot 0, byte client
    input  logic [region_aw+1:0] c0_addr,
    input  logic                 c0_addr_ok,
    input  logic                 c0_wr,
    input  logic [7:0]           c0_wdata,
    output logic                 c0_data_ok,
    output logic [7:0]           c0_dout,
    // slot 1, half-word client
    input  logic [region_aw:0]   c1_addr,
    input  logic                 c1_addr_ok,
    input  logic                 c1_wr,
    input  logic [15:0]          c1_wdata,
    output logic                 c1_data_ok,
    output logic [15:0]          c1_dout,
    // slot 2, word client
    input  logic [region_aw-1:0] c2_addr,
    input  logic                 c2_addr_ok,
    input  logic                 c2_wr,
    input  logic [31:0]          c2_wdata,
    output logic                 c2_data_ok,
    output logic [31:0]          c2_dout
);

    logic [num_slots-1:0] slot_req;
    logic [num_slots-1:0] slot_rnw;
    logic [num_slots-1:0] slot_ack;
    logic [word_aw-1:0]   slot_addr0, slot_addr1, slot_addr2;
    logic [31:0]          slot_wdata0, slot_wdata1, slot_wdata2;
    logic [3:0]           slot_wmask0, slot_wmask1, slot_wmask2;
    logic                 mem_req, mem_rnw, mem_ack, mem_busy;
    logic [word_aw-1:0]   mem_addr;
    logic [31:0]          mem_wdata, mem_rdata;
    logic [3:0]           mem_wmask;
    logic [mem_aw-1:0]    ram_addr;
    logic                 ram_rd, ram_wr;
    logic [1:0]           ram_be;
    logic [15:0]          ram_wdata, ram_rdata;

    sdram_slot #(.dw(8), .slot_id(0)) slot0_inst (
        .clk(clk), .rst(rst), .addr(c0_addr), .addr_ok(c0_addr_ok), .wr(c0_wr),
        .wdata(c0_wdata), .ack(slot_ack[0]), .rdata(mem_rdata), .data_ok(c0_data_ok),
        .dout(c0_dout), .req(slot_req[0]), .rnw(slot_rnw[0]), .waddr(slot_addr0),
        .wdata32(slot_wdata0), .wmask(slot_wmask0)
    );

    sdram_slot #(.dw(16), .slot_id(1)) slot1_inst (
        .clk(clk), .rst(rst), .addr(c1_addr), .addr_ok(c1_addr_ok), .wr(c1_wr),
        .wdata(c1_wdata), .ack(slot_ack[1]), .rdata(mem_rdata), .data_ok(c1_data_ok),
        .dout(c1_dout), .req(slot_req[1]), .rnw(slot_rnw[1]), .waddr(slot_addr1),
        .wdata32(slot_wdata1), .wmask(slot_wmask1)
    );

    sdram_slot #(.dw(32), .slot_id(2)) slot2_inst (
        .clk(clk), .rst(rst), .addr(c2_addr), .addr_ok(c2_addr_ok), .wr(c2_wr),
        .wdata(c2_wdata), .ack(slot_ack[2]), .rdata(mem_rdata), .data_ok(c2_data_ok),
        .dout(c2_dout), .req(slot_req[2]), .rnw(slot_rnw[2]), .waddr(slot_addr2),
        .wdata32(slot_wdata2), .wmask(slot_wmask2)
    );

    sdram_arbiter arbiter_inst (
        .clk(clk), .rst(rst), .req(slot_req), .rnw(slot_rnw),
        .addr0(slot_addr0), .addr1(slot_addr1), .addr2(slot_addr2),
        .wdata0(slot_wdata0), .wdata1(slot_wdata1), .wdata2(slot_wdata2),
        .wmask0(slot_wmask0), .wmask1(slot_wmask1), .wmask2(slot_wmask2),
        .mem_ack(mem_ack), .mem_busy(mem_busy), .ack(slot_ack), .mem_req(mem_req),
        .mem_rnw(mem_rnw), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wmask(mem_wmask)
    );

    sdram_ctrl ctrl_inst (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_rnw(mem_rnw),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .ram_rdata(ram_rdata), .mem_ack(mem_ack), .mem_busy(mem_busy),
        .mem_rdata(mem_rdata), .ram_addr(ram_addr), .ram_rd(ram_rd), .ram_wr(ram_wr),
        .ram_be(ram_be), .ram_wdata(ram_wdata)
    );

    sdram_array array_inst (
        .clk(clk), .addr(ram_addr), .rd(ram_rd), .wr(ram_wr), .be(ram_be),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// ==== test/sdram_sys_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_sys_asserts
    import sdram_pkg::*;
#(
    parameter int n = num_slots  // request lines watched
) (
    input logic               clk,
    input logic               rst,
    input logic [n-1:0]       req,
    input logic [n-1:0]       ack,
    input logic [n-1:0]       grant,
    input logic               data_ok,
    input logic               mem_busy,   // access in progress
    input logic               mem_req,
    input logic               mem_rnw,
    input logic [word_aw-1:0] mem_addr,
    input logic [31:0]        mem_wdata,
    input logic [3:0]         mem_wmask
);

    // at most one grant and only to a requester
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (grant & ~req) == '0)
        else $error("grant to more than one slot or to a slot without req");

    // a pending request may only fall after its ack
    req_held: assert property (@(posedge clk) disable iff (rst)
        ($past(req & ~ack) & ~req) == '0)
        else $error("req dropped before ack");

    data_ok_pulse: assert property (@(posedge clk) disable iff (rst) data_ok |=> !data_ok)
        else $error("data_ok high two cycles in a row");

    fields_stable: assert property (@(posedge clk) disable iff (rst)
        mem_busy && $past(mem_busy) |->
            $stable({mem_req, mem_rnw, mem_addr, mem_wdata, mem_wmask}))
        else $error("request fields changed during an access");

endmodule

// mem_ack is the one-cycle strobe seen by the arbiter
bind sdram_arbiter sdram_sys_asserts arb_chk (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .grant(grant), .data_ok(mem_ack),
    .mem_busy(mem_busy), .mem_req(mem_req), .mem_rnw(mem_rnw), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wmask(mem_wmask)
);

// on the slot req doubles as busy and ack stands in for the grant
bind sdram_slot sdram_sys_asserts #(.n(1)) slot_chk (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .grant(ack), .data_ok(data_ok),
    .mem_busy(req), .mem_req(req), .mem_rnw(rnw), .mem_addr(waddr),
    .mem_wdata(wdata32), .mem_wmask(wmask)
);

`default_nettype wire

// ==== test/tb_sdram_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_sys
    import sdram_pkg::*;
();

    logic                 clk;
    logic                 rst;
    logic [region_aw+1:0] c0_addr;     // byte address
    logic                 c0_addr_ok;
    logic                 c0_wr;
    logic [7:0]           c0_wdata;
    logic                 c0_data_ok;
    logic [7:0]           c0_dout;
    logic [region_aw:0]   c1_addr;     // half-word address
    logic                 c1_addr_ok;
    logic                 c1_wr;
    logic [15:0]          c1_wdata;
    logic                 c1_data_ok;
    logic [15:0]          c1_dout;
    logic [region_aw-1:0] c2_addr;     // word address
    logic                 c2_addr_ok;
    logic                 c2_wr;
    logic [31:0]          c2_wdata;
    logic                 c2_data_ok;
    logic [31:0]          c2_dout;

    logic [7:0]  model [num_slots][2**(region_aw+2)];  // byte image of each region
    logic [31:0] rng   [num_slots];                    // one xorshift stream per client
    int          pool  [num_slots][4];                 // hot words, more than two lines

    sdram_sys_top sdram_sys_top_inst (
        .clk(clk), .rst(rst),
        .c0_addr(c0_addr), .c0_addr_ok(c0_addr_ok), .c0_wr(c0_wr), .c0_wdata(c0_wdata),
        .c0_data_ok(c0_data_ok), .c0_dout(c0_dout),
        .c1_addr(c1_addr), .c1_addr_ok(c1_addr_ok), .c1_wr(c1_wr), .c1_wdata(c1_wdata),
        .c1_data_ok(c1_data_ok), .c1_dout(c1_dout),
        .c2_addr(c2_addr), .c2_addr_ok(c2_addr_ok), .c2_wr(c2_wr), .c2_wdata(c2_wdata),
        .c2_data_ok(c2_data_ok), .c2_dout(c2_dout)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw(input int s);
        rng[s] = xorshift32(rng[s]);  // advance this client's stream
        return rng[s];
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // slot s has 1 << s bytes per client word, baddr is a region byte address
    task automatic drive(input int s, input logic ok, input logic w, input int baddr,
                         input logic [31:0] d);
        case (s)
            0: begin
                c0_addr    = (region_aw+2)'(baddr);
                c0_addr_ok = ok;
                c0_wr      = w;
                c0_wdata   = d[7:0];
            end
            1: begin
                c1_addr    = (region_aw+1)'(baddr >> 1);
                c1_addr_ok = ok;
                c1_wr      = w;
                c1_wdata   = d[15:0];
            end
            default: begin
                c2_addr    = region_aw'(baddr >> 2);
                c2_addr_ok = ok;
                c2_wr      = w;
                c2_wdata   = d;
            end
        endcase
    endtask

    function automatic logic data_ok_of(input int s);
        case (s)
            0:       return c0_data_ok;
            1:       return c1_data_ok;
            default: return c2_data_ok;
        endcase
    endfunction

    function automatic logic [31:0] dout_of(input int s);
        case (s)
            0:       return 32'(c0_dout);
            1:       return 32'(c1_dout);
            default: return c2_dout;
        endcase
    endfunction

    // little endian, lane 0 is the low byte
    function automatic logic [31:0] model_read(input int s, input int baddr);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < (1 << s); i++) begin
            v[8*i +: 8] = model[s][baddr + i];
        end
        return v;
    endfunction

    task automatic model_write(input int s, input int baddr, input logic [31:0] d);
        for (int i = 0; i < (1 << s); i++) begin
            model[s][baddr + i] = d[8*i +: 8];
        end
    endtask

    // hot pool word mostly, any word in the region now and then
    function automatic int pick_addr(input int s);
        logic [31:0] r;
        int          w;
        r = draw(s);
        w = (r[5:3] == 3'd0) ? int'(r[26:16]) : pool[s][r[9:8]];
        return w * 4 + (int'(r[1:0]) & ~((1 << s) - 1));  // lane aligned to width
    endfunction

    // one client transaction, called and left 2 ns after an edge
    task automatic access(input int s, input logic w, input int baddr, input logic [31:0] d);
        logic [31:0] exp;
        logic [31:0] got;
        logic        done;
        int          cnt;
        exp = model_read(s, baddr);
        if (w) begin
            model_write(s, baddr, d);  // model follows at issue
        end
        drive(s, 1'b1, w, baddr, d);
        done = 1'b0;
        cnt  = 0;
        while (!done) begin
            @(posedge clk);
            #1;                        // outputs settled, inputs not yet moved
            done = data_ok_of(s);
            cnt++;
            if (!done && cnt >= 200) begin
                abort_run($sformatf("slot %0d got no data_ok within 200 cycles, byte addr 0x%0h",
                                    s, baddr));
            end
        end
        got = dout_of(s);
        if (!w) begin
            assert (got == exp) else begin
                abort_run($sformatf("FAILED at %0d ns: slot %0d addr 0x%0h expected 0x%0h got 0x%0h",
                                    $time, s, baddr, exp, got));
            end
        end
        #1;
        drive(s, 1'b0, 1'b0, baddr, '0);  // idle unless the caller goes on
    endtask

    task automatic directed(input int s);
        int          nb;
        int          w0;
        logic [31:0] r;
        nb = 1 << s;
        r  = draw(s);
        w0 = int'(r[10:0]) % 2040;  // leaves room for w0 + 2
        // write then read back every lane of one word
        for (int b = 0; b < 4; b += nb) begin
            access(s, 1'b1, w0 * 4 + b, draw(s));
            access(s, 1'b0, w0 * 4 + b, '0);
        end
        // same word twice more, hits
        for (int k = 0; k < 2; k++) begin
            for (int b = 0; b < 4; b += nb) begin
                access(s, 1'b0, w0 * 4 + b, '0);
            end
        end
        // three words on two lines, eviction each time
        access(s, 1'b1, (w0 + 1) * 4, draw(s));
        access(s, 1'b1, (w0 + 2) * 4, draw(s));
        for (int k = 0; k < 6; k++) begin
            access(s, 1'b0, (w0 + k % 3) * 4, '0);
        end
        // w0 + 2 is cached now, write over it and read back
        access(s, 1'b0, (w0 + 2) * 4 + 4 - nb, '0);
        access(s, 1'b1, (w0 + 2) * 4 + 4 - nb, draw(s));
        access(s, 1'b0, (w0 + 2) * 4 + 4 - nb, '0);
    endtask

    task automatic client(input int s, input int n);
        logic [31:0] r;
        for (int t = 0; t < n; t++) begin
            r = draw(s);
            access(s, r[2:0] < 3'd3, pick_addr(s), draw(s));  // 3 in 8 are writes
            if (r[7:6] == 2'd0) begin
                repeat (int'(r[9:8]) + 1) @(posedge clk);    // short pause
                #2;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        drive(0, 1'b0, 1'b0, 0, '0);
        drive(1, 1'b0, 1'b0, 0, '0);
        drive(2, 1'b0, 1'b0, 0, '0);
        for (int s = 0; s < num_slots; s++) begin
            rng[s] = 32'hf391_552f ^ (32'(s) * 32'h9e37_79b9);
            for (int i = 0; i < 2**(region_aw+2); i++) begin
                model[s][i] = 8'h00;  // array starts at zero
            end
            for (int k = 0; k < 4; k++) begin
                pool[s][k] = int'(draw(s) % 32'd2048);
            end
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // quiet clients, quiet slots
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            assert (!c0_data_ok && !c1_data_ok && !c2_data_ok) else begin
                abort_run("a slot raised data_ok while no client had a request");
            end
            #1;
        end
        for (int s = 0; s < num_slots; s++) begin
            access(s, 1'b0, pick_addr(s), '0);  // model is still all zero
        end
        for (int s = 0; s < num_slots; s++) begin
            directed(s);
        end

        fork
            client(0, 2000);
            client(1, 2000);
            client(2, 2000);
        join

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/sdram_pkg.sv
hdl/sdram_array.sv
hdl/sdram_ctrl.sv
hdl/sdram_arbiter.sv
hdl/sdram_slot.sv
hdl/sdram_sys_top.sv
test/sdram_sys_asserts.sv
test/tb_sdram_sys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram_sys
RTL_TOP   ?= sdram_sys_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
